//--- rtl/ppu_num_pkg.sv
package ppu_num_pkg;

    localparam int LANES        = 16;
    localparam int PSUM_W       = 24;
    localparam int ACC_W        = 40;    // psum x Q8.8 scale
    localparam int ACT_W        = 16;
    localparam int ACT_LSB      = 8;     // activation window starts here
    localparam int Q_W          = 8;

    localparam int FP8_EXP_BIAS = 7;     // E4M3
    localparam int RECIP_NUM    = 16320; // 255 << 6
    localparam int RECIP_SHIFT  = 6;
    localparam int Q_MAX        = 255;

    // one accelerator output row, signed lanes
    typedef struct packed {
        logic signed [LANES-1:0][PSUM_W-1:0] lane;
    } psum_row_t;

    typedef struct packed {
        logic [LANES-1:0][ACT_W-1:0] lane;
    } act_row_t;

    typedef struct packed {
        logic [LANES-1:0][Q_W-1:0] lane;
    } quant_row_t;

    typedef struct packed {
        logic [7:0] scale;   // fp8 e4m3
        logic [7:0] bias;    // unsigned
    } ppu_cfg_t;

endpackage

//--- rtl/ppu_ctrl_pkg.sv
package ppu_ctrl_pkg;

    localparam int ROWS   = 16;  // rows per batch
    localparam int ROW_AW = 4;

    // idle   waiting for the first row
    // fill   collecting rows into the buffer
    // recip  one cycle to latch the reciprocal
    // drain  streaming the batch out
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FILL,
        PH_RECIP,
        PH_DRAIN
    } ppu_phase_e;

endpackage

//--- rtl/ppu_affine.sv
`timescale 1ns/100ps

module ppu_affine import ppu_num_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      take,
    input  psum_row_t in_row,
    input  ppu_cfg_t  in_cfg,
    output logic      act_valid,
    output act_row_t  act_row
);

    logic [3:0]         exp_f;
    logic [8:0]         base_f;
    logic [16:0]        mag_f;
    logic [14:0]        mag_sat;
    logic signed [15:0] scale_q;    // Q8.8
    act_row_t           act_nxt;

    assign exp_f  = in_cfg.scale[6:3];
    assign base_f = {1'b1, in_cfg.scale[2:0], 5'b0};  // 1.mmm in Q8.8

    always_comb begin
        if (exp_f >= 4'(FP8_EXP_BIAS)) begin
            mag_f = {8'b0, base_f} << (exp_f - 4'(FP8_EXP_BIAS));
        end else begin
            mag_f = {8'b0, base_f} >> (4'(FP8_EXP_BIAS) - exp_f);
        end
    end

    // top exponents would overflow signed Q8.8
    assign mag_sat = (mag_f > 17'h07fff) ? 15'h7fff : mag_f[14:0];
    assign scale_q = in_cfg.scale[7] ? -$signed({1'b0, mag_sat}) : $signed({1'b0, mag_sat});

    always_comb begin
        logic signed [ACC_W-1:0] prod;
        logic signed [ACC_W-1:0] acc;
        for (int i = 0; i < LANES; i++) begin
            prod = $signed(in_row.lane[i]) * scale_q;
            acc  = (prod >>> 8) + $signed({1'b0, in_cfg.bias});  // drop Q8.8 fraction
            if (acc < 0) begin
                acc = '0;  // relu
            end
            // any bit above the window saturates
            if (|acc[ACC_W-1:ACT_LSB+ACT_W]) begin
                act_nxt.lane[i] = '1;
            end else begin
                act_nxt.lane[i] = acc[ACT_LSB +: ACT_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_valid <= 1'b0;
        end else begin
            act_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            act_row <= act_nxt;
        end
    end

endmodule

//--- rtl/ppu_row_buffer.sv
`timescale 1ns/100ps

module ppu_row_buffer import ppu_num_pkg::*, ppu_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     act_valid,
    input  logic     rd_en,
    input  act_row_t act_row,
    output act_row_t rd_row,
    output logic     rd_valid
);

    act_row_t          mem [ROWS];
    logic [ROW_AW-1:0] wr_ptr;
    logic [ROW_AW-1:0] rd_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (act_valid) wr_ptr <= wr_ptr + 1'b1;
                if (rd_en)     rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid) mem[wr_ptr] <= act_row;
        if (rd_en)     rd_row <= mem[rd_ptr];  // registered read
    end

endmodule

//--- rtl/ppu_max_recip.sv
`timescale 1ns/100ps

module ppu_max_recip import ppu_num_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             act_valid,
    input  logic             clear,
    input  logic             recip_load,
    input  act_row_t         act_row,
    output logic [ACT_W-1:0] batch_max,
    output logic [ACT_W-1:0] recip
);

    logic [ACT_W-1:0] max_nxt;

    // fold all lanes of the row into the running max
    always_comb begin
        max_nxt = batch_max;
        for (int i = 0; i < LANES; i++) begin
            if (act_row.lane[i] > max_nxt) begin
                max_nxt = act_row.lane[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            batch_max <= '0;
        end else if (clear) begin
            batch_max <= '0;
        end else if (act_valid) begin
            batch_max <= max_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (recip_load) begin
            if (batch_max == '0) begin
                recip <= '1;  // all-zero batch
            end else begin
                recip <= ACT_W'(RECIP_NUM / batch_max);
            end
        end
    end

endmodule

//--- rtl/ppu_ctrl.sv
`timescale 1ns/100ps

module ppu_ctrl import ppu_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic act_valid,
    output logic take,
    output logic recip_load,
    output logic rd_en,
    output logic rd_last,
    output logic clear,
    output logic busy
);

    ppu_phase_e        phase;
    logic [ROW_AW-1:0] take_cnt;
    logic [ROW_AW-1:0] wr_cnt;
    logic [ROW_AW-1:0] rd_cnt;
    logic              last_take;
    logic              last_wr;
    logic              last_rd;

    // take_cnt wraps to zero once the whole batch is in
    assign take = in_valid && (phase == PH_IDLE || (phase == PH_FILL && take_cnt != '0));

    assign last_take  = take && take_cnt == ROW_AW'(ROWS - 1);
    assign last_wr    = act_valid && wr_cnt == ROW_AW'(ROWS - 1);
    assign recip_load = phase == PH_RECIP;
    assign rd_en      = phase == PH_DRAIN && !rd_last && !clear;  // tail waits for quantizer
    assign last_rd    = rd_en && rd_cnt == ROW_AW'(ROWS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_IDLE;
            take_cnt <= '0;
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            rd_last  <= 1'b0;
            clear    <= 1'b0;
            busy     <= 1'b0;
        end else begin
            rd_last <= last_rd;   // lines up with rd_valid
            clear   <= rd_last;   // lines up with out_last
            if (take)      take_cnt <= take_cnt + 1'b1;
            if (act_valid) wr_cnt   <= wr_cnt + 1'b1;
            if (rd_en)     rd_cnt   <= rd_cnt + 1'b1;

            if (last_take) begin
                busy <= 1'b1;
            end else if (clear) begin
                busy <= 1'b0;
            end

            case (phase)
                PH_IDLE: begin
                    if (take) phase <= PH_FILL;
                end
                PH_FILL: begin
                    if (last_wr) phase <= PH_RECIP;
                end
                PH_RECIP: begin
                    phase <= PH_DRAIN;
                end
                PH_DRAIN: begin
                    if (clear) phase <= PH_IDLE;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/ppu_quantizer.sv
`timescale 1ns/100ps

module ppu_quantizer import ppu_num_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_valid,
    input  logic        rd_last,
    input  act_row_t    rd_row,
    input  logic [15:0] recip,
    output logic        out_valid,
    output logic        out_last,
    output quant_row_t  out_row
);

    quant_row_t q_nxt;

    always_comb begin
        logic [ACT_W+15:0] prod;
        logic [ACT_W+15:0] scaled;
        for (int i = 0; i < LANES; i++) begin
            prod   = rd_row.lane[i] * recip;
            scaled = prod >> RECIP_SHIFT;
            q_nxt.lane[i] = (scaled > Q_MAX) ? Q_W'(Q_MAX) : scaled[Q_W-1:0];  // clamp
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= rd_valid;
            out_last  <= rd_valid && rd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) out_row <= q_nxt;
    end

endmodule

//--- rtl/ppu_top.sv
`timescale 1ns/100ps

module ppu_top import ppu_num_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  psum_row_t        in_row,
    input  ppu_cfg_t         in_cfg,
    output logic             busy,
    output logic             out_valid,
    output logic             out_last,
    output quant_row_t       out_row,
    output logic [ACT_W-1:0] out_max
);

    logic             take;
    logic             act_valid;
    act_row_t         act_row;
    logic             recip_load;
    logic             rd_en;
    logic             rd_last;
    logic             clear;
    act_row_t         rd_row;
    logic             rd_valid;
    logic [ACT_W-1:0] recip;

    ppu_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .act_valid  (act_valid),
        .take       (take),
        .recip_load (recip_load),
        .rd_en      (rd_en),
        .rd_last    (rd_last),
        .clear      (clear),
        .busy       (busy)
    );

    ppu_affine i_affine (
        .clk       (clk),
        .rst_n     (rst_n),
        .take      (take),
        .in_row    (in_row),
        .in_cfg    (in_cfg),
        .act_valid (act_valid),
        .act_row   (act_row)
    );

    ppu_row_buffer i_row_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .act_valid (act_valid),
        .rd_en     (rd_en),
        .act_row   (act_row),
        .rd_row    (rd_row),
        .rd_valid  (rd_valid)
    );

    ppu_max_recip i_max_recip (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_valid  (act_valid),
        .clear      (clear),
        .recip_load (recip_load),
        .act_row    (act_row),
        .batch_max  (out_max),   // held until the out_last cycle
        .recip      (recip)
    );

    ppu_quantizer i_quantizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_last   (rd_last),
        .rd_row    (rd_row),
        .recip     (recip),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_row   (out_row)
    );

endmodule

//--- testbench/ppu_chk.sv
`timescale 1ns/100ps

module ppu_chk import ppu_ctrl_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       take,
    input logic       busy,
    input logic       rd_en,
    input logic       rd_last,
    input ppu_phase_e phase
);

    // out_valid trails rd_en by two cycles
    take_vs_output: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rd_en, 2) |-> !take)
        else $error("row taken while the output stream runs");

    take_vs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(take && busy))
        else $error("row taken while busy");

    // out_last trails rd_last by one cycle
    busy_falls: assert property (@(posedge clk) disable iff (!rst_n)
        rd_last |-> ##2 !busy)
        else $error("busy still high after the last output row");

    busy_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == PH_RECIP || phase == PH_DRAIN) |-> busy)
        else $error("busy low while the batch is being processed");

endmodule

bind ppu_ctrl ppu_chk i_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .take    (take),
    .busy    (busy),
    .rd_en   (rd_en),
    .rd_last (rd_last),
    .phase   (phase)
);

//--- testbench/ppu_tb.sv
`timescale 1ns/100ps

module ppu_tb import ppu_num_pkg::*, ppu_ctrl_pkg::*; ();

    localparam int NUM_TESTS      = 9;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 60 + 100;

    typedef struct packed {
        logic [7:0]  scale;     // fp8 e4m3 code
        logic [7:0]  bias;
        logic [23:0] bound;     // lane magnitude limit
        logic        pos_only;  // no negative lanes
        logic        extra;     // offer rows while busy
    } test_t;

    //   scale   bias   bound        pos   extra
    test_t tests [NUM_TESTS] = '{
        '{8'h38, 8'h00, 24'h7fffff, 1'b0, 1'b0},  // 1.0
        '{8'h38, 8'h00, 24'h003fff, 1'b0, 1'b0},  // small max
        '{8'h30, 8'h40, 24'h0fffff, 1'b0, 1'b0},  // 0.5
        '{8'h2c, 8'hff, 24'h03ffff, 1'b0, 1'b1},  // 0.375
        '{8'h4a, 8'h10, 24'h7fffff, 1'b0, 1'b1},  // 5.0 partly saturating
        '{8'h60, 8'h80, 24'h7fffff, 1'b0, 1'b0},  // 32.0 so max hits ffff
        '{8'hb8, 8'h00, 24'h7fffff, 1'b1, 1'b1},  // -1.0 gives all zero
        '{8'hc0, 8'h00, 24'h00ffff, 1'b0, 1'b0},  // -2.0 on mixed signs
        '{8'h38, 8'h00, 24'h000000, 1'b0, 1'b1}   // zero data
    };

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    psum_row_t        in_row;
    ppu_cfg_t         in_cfg;
    logic             busy;
    logic             out_valid;
    logic             out_last;
    quant_row_t       out_row;
    logic [ACT_W-1:0] out_max;

    int               errors = 0;
    int               failed_tests = 0;
    int               cycles = 0;
    psum_row_t        rows  [ROWS];
    quant_row_t       exp_q [ROWS];
    logic [ACT_W-1:0] exp_max;

    ppu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_cfg    (in_cfg),
        .busy      (busy),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_row   (out_row),
        .out_max   (out_max)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fp8 e4m3 to signed q8.8 without subnormals
    function automatic int decode_scale(logic [7:0] code);
        int e;
        int mag;
        e   = int'(code[6:3]);
        mag = ((8 + int'(code[2:0])) << (e + 5)) >> 7;
        return code[7] ? -mag : mag;
    endfunction

    function automatic logic [ACT_W-1:0] lane_activation(logic signed [PSUM_W-1:0] psum,
                                                         int q, logic [7:0] bias);
        longint acc;
        acc = ((longint'(psum) * q) >>> 8) + longint'(bias);
        if (acc < 0) acc = 0;                                  // relu
        if (acc >= (longint'(1) << (ACT_LSB + ACT_W))) return '1;
        return acc[ACT_LSB +: ACT_W];
    endfunction

    function automatic psum_row_t random_row(logic [23:0] bound, logic pos_only);
        psum_row_t row;
        int        v;
        for (int l = 0; l < LANES; l++) begin
            if (pos_only) v = int'($urandom_range(bound, 0));
            else          v = int'($urandom_range(2 * bound, 0)) - int'(bound);
            row.lane[l] = v[PSUM_W-1:0];
        end
        return row;
    endfunction

    task automatic predict_batch(test_t tc);
        logic [ACT_W-1:0] act [ROWS][LANES];
        logic [ACT_W-1:0] recip;
        longint           prod;
        int               q;
        q       = decode_scale(tc.scale);
        exp_max = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int l = 0; l < LANES; l++) begin
                act[r][l] = lane_activation(rows[r].lane[l], q, tc.bias);
                if (act[r][l] > exp_max) exp_max = act[r][l];
            end
        end
        recip = (exp_max == 0) ? 16'hffff : 16'(RECIP_NUM / exp_max);
        for (int r = 0; r < ROWS; r++) begin
            for (int l = 0; l < LANES; l++) begin
                prod = (longint'(act[r][l]) * longint'(recip)) >> RECIP_SHIFT;
                exp_q[r].lane[l] = (prod > Q_MAX) ? 8'(Q_MAX) : prod[Q_W-1:0];
            end
        end
    endtask

    task automatic drive_batch(test_t tc);
        for (int r = 0; r < ROWS; r++) begin
            @(negedge clk);
            if ($urandom_range(3, 0) == 0) begin  // occasional idle gap
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_row   = rows[r];
            in_cfg   = '{scale: tc.scale, bias: tc.bias};
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (tc.extra) begin
            // junk rows offered while busy
            for (int k = 0; k < 12; k++) begin
                in_valid = 1'b1;
                in_row   = random_row(24'h7fffff, 1'b0);
                in_cfg   = ppu_cfg_t'(16'($urandom));
                @(negedge clk);
            end
            in_valid = 1'b0;
        end
    endtask

    task automatic collect_batch(int t);
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        for (int r = 0; r < ROWS; r++) begin
            if (r > 0) @(negedge clk);
            assert (out_valid === 1'b1) else begin
                $display("error: test %0d row %0d out_valid 0x%h expected 0x1", t, r, out_valid);
                errors++;
            end
            assert (busy === 1'b1) else begin
                $display("error: test %0d row %0d busy 0x%h expected 0x1", t, r, busy);
                errors++;
            end
            assert (out_last === (r == ROWS - 1)) else begin
                $display("error: test %0d row %0d out_last 0x%h expected 0x%h",
                         t, r, out_last, r == ROWS - 1);
                errors++;
            end
            assert (out_row === exp_q[r]) else begin
                $display("error: test %0d row %0d out_row 0x%h expected 0x%h",
                         t, r, out_row, exp_q[r]);
                errors++;
            end
            assert (out_max === exp_max) else begin
                $display("error: test %0d row %0d out_max 0x%h expected 0x%h",
                         t, r, out_max, exp_max);
                errors++;
            end
        end
        @(negedge clk);
        assert (out_valid === 1'b0 && busy === 1'b0) else begin
            $display("error: test %0d after last row out_valid 0x%h busy 0x%h expected 0x0",
                     t, out_valid, busy);
            errors++;
        end
    endtask

    task automatic idle_outputs_low(string when);
        assert (busy === 1'b0 && out_valid === 1'b0 && out_last === 1'b0) else begin
            $display("error: %s busy 0x%h out_valid 0x%h out_last 0x%h expected 0x0",
                     when, busy, out_valid, out_last);
            errors++;
        end
    endtask

    task automatic run_test(int t);
        for (int r = 0; r < ROWS; r++) begin
            rows[r] = random_row(tests[t].bound, tests[t].pos_only);
        end
        predict_batch(tests[t]);
        fork
            drive_batch(tests[t]);
            collect_batch(t);
        join
    endtask

    initial begin
        int errs_before;
        void'($urandom(32'h7dca));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_row   = '0;
        in_cfg   = '0;
        repeat (16) @(negedge clk);
        idle_outputs_low("in reset");
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        idle_outputs_low("after reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            run_test(t);
            if (errors != errs_before) failed_tests++;
            $display("test %0d scale 0x%h bias 0x%h max 0x%h: %s", t, tests[t].scale,
                     tests[t].bias, exp_max, (errors == errs_before) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
rtl/ppu_num_pkg.sv
rtl/ppu_ctrl_pkg.sv
rtl/ppu_affine.sv
rtl/ppu_row_buffer.sv
rtl/ppu_max_recip.sv
rtl/ppu_ctrl.sv
rtl/ppu_quantizer.sv
rtl/ppu_top.sv
testbench/ppu_chk.sv
testbench/ppu_tb.sv

//--- Makefile
TOOL       := verilator
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := ppu_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
